// ==== mmu_vectors.txt ====
# W idx ppn perms : page table write, hex
# R L|S va priv asid ppn perms faults : request, faults = pf insn store load (binary)
# F va asid : fence, zero means all; perms bits D A G U X W R V, valid at bit 0
# miss then hit
W 01 12345 0c7
R L 00001abc 1 001 12345 0c7 0000
R L 00001004 1 001 12345 0c7 0000
R S 00001ff8 1 001 12345 0c7 0000
# one page under three asids, stale entries show what is still cached
W 02 00abc 0c7
R L 00002000 1 001 00abc 0c7 0000
R L 00002000 1 002 00abc 0c7 0000
W 02 00def 0c7
R L 00002000 1 001 00abc 0c7 0000
R L 00002000 1 003 00def 0c7 0000
R L 00002000 1 001 00abc 0c7 0000
R L 00002000 1 002 00def 0c7 0000
R L 00002000 1 001 00abc 0c7 0000
# permission faults
W 03 00103 043
R L 00003000 1 001 00103 043 0000
R S 00003000 1 001 00103 043 0010
W 04 00104 047
R S 00004000 1 001 00104 047 0010
R L 00004000 1 001 00104 047 0000
W 05 00105 087
R L 00005000 1 001 00105 087 0001
R S 00005000 1 001 00105 087 0010
W 06 00106 0d7
R L 00006000 1 001 00106 0d7 0001
R L 00006000 0 001 00106 0d7 0000
R S 00006000 0 001 00106 0d7 0000
R L 00001000 0 001 12345 0c7 0001
# page faults, invalid pte and vpn beyond the table
W 08 11111 0c6
R L 00008000 1 001 00000 000 1000
R L 00041000 1 001 00000 000 1000
R S 00008000 1 001 00000 000 1000
# va fence picks up a changed pte
W 01 22222 0c7
R L 00001000 1 001 12345 0c7 0000
F 00001000 000
R L 00001000 1 001 22222 0c7 0000
# asid fence spares global pages and other asids
W 0f 33333 0e7
R L 0000f000 1 001 33333 0e7 0000
W 0f 44444 0e7
W 02 00fed 0c7
W 01 55555 0c7
F 00000000 001
R L 0000f000 1 001 33333 0e7 0000
R L 00002000 1 002 00def 0c7 0000
R L 00002000 1 001 00fed 0c7 0000
R L 00002000 1 002 00def 0c7 0000
R L 00001000 1 001 55555 0c7 0000
# full fence clears global pages too
F 00000000 000
R L 0000f000 1 001 44444 0e7 0000
R L 00002000 1 002 00fed 0c7 0000

// ==== all.f ====
sv32_pkg.sv
tlb_pkg.sv
tlb_sram.sv
page_perm_check.sv
tlb.sv
pte_walker.sv
mmu_top.sv
tb_clock.sv
tb_mmu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mmu
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ns
PASS_MSG  ?= === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the testbench printed the pass message
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qF -- "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_mmu.sv ====
/*
 * Testbench for the Sv32 MMU with page table loads,
 * translation requests and fences read from the vector file
 */

`timescale 1ns/1ns

module tb_mmu import sv32_pkg::*, tlb_pkg::*; ();

    localparam int DRIVE_DLY     = 2;  // ns after the rising edge
    localparam int RESET_CYCLES  = 16;
    localparam int REQ_TIMEOUT   = 40;
    localparam int FENCE_TIMEOUT = N_SETS * TLB_ASSOC + 20;

    logic                   CLK;
    logic                   nRST;
    logic                   req_ren;
    logic                   req_wen;
    word_t                  req_addr;
    logic [1:0]             priv;
    logic [ASID_BITS-1:0]   asid;
    logic                   busy;
    pte_t                   hit_pte;
    logic                   fault_load;
    logic                   fault_store;
    logic                   fault_insn;
    logic                   fence;
    word_t                  fence_va;
    logic [ASID_BITS-1:0]   fence_asid;
    logic                   fence_done;
    logic                   pt_wen;
    logic [PT_IDX_BITS-1:0] pt_waddr;
    word_t                  pt_wdata;
    logic                   page_fault;

    int checks;
    int errors;
    int timeouts;
    int vec_no;
    bit timed_out;

    tb_clock #(.PERIOD(20)) i_clock (.CLK(CLK));

    mmu_top i_mmu_top (
        .CLK(CLK), .nRST(nRST),
        .req_ren(req_ren), .req_wen(req_wen), .req_addr(req_addr),
        .priv(priv), .asid(asid), .busy(busy), .hit_pte(hit_pte),
        .fault_load(fault_load), .fault_store(fault_store), .fault_insn(fault_insn),
        .fence(fence), .fence_va(fence_va), .fence_asid(fence_asid),
        .fence_done(fence_done),
        .pt_wen(pt_wen), .pt_waddr(pt_waddr), .pt_wdata(pt_wdata),
        .page_fault(page_fault)
    );

    task automatic check_pte(input pte_t got, input pte_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s pte ppn %h perms %h, expected ppn %h perms %h",
                     $time, what, got.ppn, got.perms, exp.ppn, exp.perms);
        end
    endtask

    // page_fault insn store load from msb down
    task automatic check_faults(input logic [3:0] got, input logic [3:0] exp,
                                input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s faults %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic reset_dut();
        nRST       = 1'b0;
        req_ren    = 1'b0;
        req_wen    = 1'b0;
        req_addr   = '0;
        priv       = PRV_S;
        asid       = '0;
        fence      = 1'b0;
        fence_va   = '0;
        fence_asid = '0;
        pt_wen     = 1'b0;
        pt_waddr   = '0;
        pt_wdata   = '0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #DRIVE_DLY;
        nRST = 1'b1;
        // invalidate sweep takes one set per cycle
        for (int i = 0; i < N_SETS; i++) begin
            @(negedge CLK);
            if (!busy || fence_done) begin
                errors++;
                $display("ERROR at %0t ns: busy low or fence_done high during reset sweep",
                         $time);
            end
            check_faults({page_fault, fault_insn, fault_store, fault_load}, 4'b0000,
                         "reset sweep");
        end
    endtask

    task automatic load_pte(input logic [PT_IDX_BITS-1:0] idx, input pte_t pte);
        @(posedge CLK);
        #DRIVE_DLY;
        pt_wen   = 1'b1;
        pt_waddr = idx;
        pt_wdata = word_t'(pte);
        @(posedge CLK);
        #DRIVE_DLY;
        pt_wen = 1'b0;
    endtask

    task automatic translate(input byte kind, input word_t addr, input logic [1:0] prv,
                             input logic [ASID_BITS-1:0] id, input pte_t exp_pte,
                             input logic [3:0] exp_faults);
        int    wait_cycles;
        logic  done;
        string what;
        wait_cycles = 0;
        done        = 1'b0;
        what        = $sformatf("vector %0d (%c %h asid %0d)", vec_no, kind, addr, id);
        @(posedge CLK);
        #DRIVE_DLY;
        req_ren  = (kind == "L");
        req_wen  = (kind == "S");
        req_addr = addr;
        priv     = prv;
        asid     = id;
        while (!done && !timed_out) begin
            @(negedge CLK);
            if (!busy || page_fault) begin
                done = 1'b1;
            end else if (wait_cycles == REQ_TIMEOUT) begin
                timed_out = 1'b1;
                timeouts++;
                $display("Timeout: request %s never completed", what);
            end else begin
                wait_cycles++;
            end
        end
        if (done) begin
            check_faults({page_fault, fault_insn, fault_store, fault_load}, exp_faults, what);
            if (!busy && exp_faults[3]) begin
                errors++;
                $display("ERROR at %0t ns: %s hit although a page fault was expected",
                         $time, what);
            end else if (!busy) begin
                check_pte(hit_pte, exp_pte, what);
            end
        end
        @(posedge CLK);  // completion edge
        #DRIVE_DLY;
        req_ren = 1'b0;
        req_wen = 1'b0;
    endtask

    task automatic run_fence(input word_t va, input logic [ASID_BITS-1:0] id);
        int   wait_cycles;
        logic done;
        wait_cycles = 0;
        done        = 1'b0;
        @(posedge CLK);
        #DRIVE_DLY;
        fence      = 1'b1;
        fence_va   = va;
        fence_asid = id;
        @(posedge CLK);
        #DRIVE_DLY;
        fence = 1'b0;
        while (!done && !timed_out) begin
            @(negedge CLK);
            if (fence_done) begin
                done = 1'b1;
            end else if (wait_cycles == FENCE_TIMEOUT) begin
                timed_out = 1'b1;
                timeouts++;
                $display("Timeout: fence va %h asid %0d never finished", va, id);
            end else begin
                wait_cycles++;
            end
        end
    endtask

    initial begin
        int            fd;
        int            code;
        byte           kind;
        byte           acc;
        logic [31:0]   f_idx;
        logic [31:0]   f_ppn;
        logic [31:0]   f_perms;
        logic [31:0]   f_addr;
        logic [31:0]   f_prv;
        logic [31:0]   f_asid;
        logic [3:0]    f_faults;
        logic [1023:0] skip_line;
        checks    = 0;
        errors    = 0;
        timeouts  = 0;
        vec_no    = 0;
        timed_out = 1'b0;
        reset_dut();
        fd = $fopen("mmu_vectors.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open mmu_vectors.txt");
        end else begin
            code = $fscanf(fd, " %c", kind);
            while (code == 1 && !timed_out) begin
                case (kind)
                    "#": code = $fgets(skip_line, fd);
                    "W": begin
                        code = $fscanf(fd, "%h %h %h", f_idx, f_ppn, f_perms);
                        if (code != 3) begin
                            errors++;
                            $display("Malformed page table write in mmu_vectors.txt");
                        end
                        load_pte(f_idx[PT_IDX_BITS-1:0],
                                 pte_t'({f_ppn[PPN_BITS-1:0], f_perms[9:0]}));
                    end
                    "R": begin
                        code = $fscanf(fd, " %c %h %h %h %h %h %b", acc, f_addr, f_prv,
                                       f_asid, f_ppn, f_perms, f_faults);
                        vec_no++;
                        if (code != 7) begin
                            errors++;
                            $display("Malformed request in vector %0d", vec_no);
                        end
                        translate(acc, f_addr, f_prv[1:0], f_asid[ASID_BITS-1:0],
                                  pte_t'({f_ppn[PPN_BITS-1:0], f_perms[9:0]}), f_faults);
                    end
                    "F": begin
                        code = $fscanf(fd, "%h %h", f_addr, f_asid);
                        vec_no++;
                        if (code != 2) begin
                            errors++;
                            $display("Malformed fence in vector %0d", vec_no);
                        end
                        run_fence(f_addr, f_asid[ASID_BITS-1:0]);
                    end
                    default: begin
                        errors++;
                        $display("Unknown line kind '%c' in mmu_vectors.txt", kind);
                    end
                endcase
                code = $fscanf(fd, " %c", kind);
            end
            $fclose(fd);
        end
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0 && vec_no > 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== tb_clock.sv ====
/*
 * Free-running testbench clock
 */

`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD = 20 // ns
) (
    output logic CLK
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

endmodule

// ==== mmu_top.sv ====
/*
 * Sv32 MMU top: data TLB and page table walker
 */

`timescale 1ns/1ns

module mmu_top import sv32_pkg::*, tlb_pkg::*; (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   req_ren,
    input  logic                   req_wen,
    input  word_t                  req_addr,
    input  logic [1:0]             priv,
    input  logic [ASID_BITS-1:0]   asid,
    output logic                   busy,
    output pte_t                   hit_pte,
    output logic                   fault_load,
    output logic                   fault_store,
    output logic                   fault_insn,
    input  logic                   fence,
    input  word_t                  fence_va,
    input  logic [ASID_BITS-1:0]   fence_asid,
    output logic                   fence_done,
    input  logic                   pt_wen,
    input  logic [PT_IDX_BITS-1:0] pt_waddr,
    input  word_t                  pt_wdata,
    output logic                   page_fault
);

    logic                walk_req;
    logic [VPN_BITS-1:0] walk_vpn;
    logic                walk_valid;
    pte_t                walk_pte;

    tlb #(.IS_ITLB(1'b0)) i_tlb (
        .CLK(CLK), .nRST(nRST),
        .req_ren(req_ren), .req_wen(req_wen), .req_addr(req_addr),
        .priv(priv), .asid(asid), .busy(busy), .hit_pte(hit_pte),
        .fault_load(fault_load), .fault_store(fault_store), .fault_insn(fault_insn),
        .fence(fence), .fence_va(fence_va), .fence_asid(fence_asid),
        .fence_done(fence_done),
        .walk_req(walk_req), .walk_vpn(walk_vpn), .walk_valid(walk_valid),
        .walk_pte(walk_pte), .walk_fault(page_fault)
    );

    // walk fault doubles as the pipeline's page fault
    pte_walker i_walker (
        .CLK(CLK), .nRST(nRST),
        .pt_wen(pt_wen), .pt_waddr(pt_waddr), .pt_wdata(pt_wdata),
        .walk_req(walk_req), .walk_vpn(walk_vpn), .walk_valid(walk_valid),
        .walk_pte(walk_pte), .walk_fault(page_fault)
    );

endmodule

// ==== pte_walker.sv ====
/*
 * Single-level page table walker with its page table memory,
 * load port and fixed-latency PTE fetch
 */

`timescale 1ns/1ns

module pte_walker import sv32_pkg::*, tlb_pkg::*; (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   pt_wen,
    input  logic [PT_IDX_BITS-1:0] pt_waddr,
    input  word_t                  pt_wdata,
    input  logic                   walk_req,
    input  logic [VPN_BITS-1:0]    walk_vpn,
    output logic                   walk_valid,
    output pte_t                   walk_pte,
    output logic                   walk_fault
);

    typedef logic [$clog2(WALK_LATENCY + 1)-1:0] cnt_t;

    pte_t pt_mem [PT_ENTRIES];

    logic active;  // walk in flight
    cnt_t cnt;     // cycles left before the answer
    logic answer;
    logic vpn_high;
    pte_t entry;

    always_ff @(posedge CLK) begin
        if (pt_wen) begin
            pt_mem[pt_waddr] <= pte_t'(pt_wdata);
        end
    end

    assign entry    = pt_mem[walk_vpn[PT_IDX_BITS-1:0]];
    assign vpn_high = |walk_vpn[VPN_BITS-1:PT_IDX_BITS]; // outside the table

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            active <= 1'b0;
            cnt    <= '0;
        end else if (active) begin
            if (cnt == '0) begin
                active <= 1'b0;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end else if (walk_req) begin
            active <= 1'b1;
            cnt    <= cnt_t'(WALK_LATENCY - 1);
        end
    end

    assign answer = active && (cnt == '0);

    assign walk_pte   = entry;
    assign walk_valid = answer && entry.perms.valid && !vpn_high;
    assign walk_fault = answer && (!entry.perms.valid || vpn_high);

endmodule

// ==== tlb.sv ====
/*
 * Set-associative TLB: lookup under ASID, round-robin fill on a miss,
 * invalidate sweep after reset and selective fence sweep
 */

`timescale 1ns/1ns

module tlb import sv32_pkg::*, tlb_pkg::*; #(
    parameter bit IS_ITLB = 1'b0
) (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 req_ren,
    input  logic                 req_wen,
    input  word_t                req_addr,
    input  logic [1:0]           priv,
    input  logic [ASID_BITS-1:0] asid,
    output logic                 busy,
    output pte_t                 hit_pte,
    output logic                 fault_load,
    output logic                 fault_store,
    output logic                 fault_insn,
    input  logic                 fence,
    input  word_t                fence_va,
    input  logic [ASID_BITS-1:0] fence_asid,
    output logic                 fence_done,
    output logic                 walk_req,
    output logic [VPN_BITS-1:0]  walk_vpn,
    input  logic                 walk_valid,
    input  pte_t                 walk_pte,
    input  logic                 walk_fault
);

    typedef enum logic [1:0] {ST_SWEEP, ST_HIT, ST_FETCH, ST_FENCE} tlb_state_t;

    tlb_state_t state, next_state;

    logic [VPN_BITS-1:0]   vpn;
    set_idx_t              set_idx;
    logic [N_TAG_BITS-1:0] req_tag;
    logic                  req;
    access_t               access;

    tlb_tag_row_t tag_rd, tag_wval, tag_wmask;
    tlb_pte_row_t pte_rd, pte_wval, pte_wmask;
    set_idx_t     sram_sel;
    logic         sram_wen;

    logic     hit, lookup_hit;
    way_idx_t hit_way, repl_way;

    logic [N_SETS-1:0][N_WAY_BITS-1:0] last_used, last_used_n;

    set_idx_t fc_set, fc_set_n;  // sweep / fence position
    way_idx_t fc_way, fc_way_n;
    logic     fc_done, fc_done_n;

    word_t                fence_va_q;
    logic [ASID_BITS-1:0] fence_asid_q;
    tlb_tag_t             fence_tag;
    logic                 fence_hit;

    assign vpn     = req_addr[PAGE_OFFSET_BITS +: VPN_BITS];
    assign set_idx = vpn[N_SET_BITS-1:0];
    assign req_tag = vpn[VPN_BITS-1:N_SET_BITS];
    assign req     = req_ren || req_wen;

    assign sram_sel = (state == ST_SWEEP || state == ST_FENCE) ? fc_set : set_idx;

    tlb_sram #(.ROW_T(tlb_tag_row_t)) i_tag_sram (
        .CLK(CLK), .nRST(nRST), .sel(sram_sel), .wen(sram_wen),
        .wval(tag_wval), .wmask(tag_wmask), .rval(tag_rd)
    );

    tlb_sram #(.ROW_T(tlb_pte_row_t)) i_pte_sram (
        .CLK(CLK), .nRST(nRST), .sel(sram_sel), .wen(sram_wen),
        .wval(pte_wval), .wmask(pte_wmask), .rval(pte_rd)
    );

    // compare every way of the indexed set
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int i = 0; i < TLB_ASSOC; i++) begin
            if (tag_rd[i].valid && tag_rd[i].asid == asid && tag_rd[i].vpn_tag == req_tag) begin
                hit     = 1'b1;
                hit_way = way_idx_t'(i);
            end
        end
    end

    assign lookup_hit = (state == ST_HIT) && req && hit;
    assign busy       = !lookup_hit;
    assign hit_pte    = lookup_hit ? pte_rd[hit_way] : '0;

    // victim is the way after the last used one
    always_comb begin
        if (last_used[set_idx] == way_idx_t'(TLB_ASSOC - 1)) begin
            repl_way = '0;
        end else begin
            repl_way = last_used[set_idx] + 1'b1;
        end
    end

    generate
        if (IS_ITLB) begin : g_itlb
            assign access = ACCESS_INSN;
        end else begin : g_dtlb
            assign access = req_wen ? ACCESS_STORE : (req_ren ? ACCESS_LOAD : ACCESS_NONE);
        end
    endgenerate

    page_perm_check i_perm_check (
        .check(lookup_hit), .access(access), .priv(priv), .pte(hit_pte),
        .fault_load(fault_load), .fault_store(fault_store), .fault_insn(fault_insn)
    );

    // 0 in fence_va or fence_asid means any; asid fences spare global pages
    assign fence_tag = tag_rd[fc_way];
    assign fence_hit = fence_tag.valid &&
        (~|fence_va_q || {fence_tag.vpn_tag, fc_set} == fence_va_q[PAGE_OFFSET_BITS +: VPN_BITS]) &&
        (~|fence_asid_q ||
         (fence_tag.asid == fence_asid_q && !pte_rd[fc_way].perms.global_page));

    assign walk_req = (state == ST_FETCH);
    assign walk_vpn = vpn;

    always_comb begin
        next_state  = state;
        fc_set_n    = fc_set;
        fc_way_n    = fc_way;
        fc_done_n   = fc_done;
        last_used_n = last_used;
        sram_wen    = 1'b0;
        tag_wval    = '0;
        tag_wmask   = '1;
        pte_wval    = '0;
        pte_wmask   = '1;
        fence_done  = 1'b0;

        case (state)
            ST_SWEEP: begin
                sram_wen  = 1'b1;
                tag_wmask = '0; // whole set invalid
                if (fc_set == set_idx_t'(N_SETS - 1)) begin
                    fc_set_n   = '0;
                    next_state = ST_HIT;
                end else begin
                    fc_set_n = fc_set + 1'b1;
                end
            end
            ST_HIT: begin
                if (lookup_hit) begin
                    last_used_n[set_idx] = hit_way;
                end else if (fence) begin
                    next_state = ST_FENCE;
                end else if (req) begin
                    next_state = ST_FETCH;
                end
            end
            ST_FETCH: begin
                if (walk_valid) begin
                    sram_wen                    = 1'b1;
                    tag_wval[repl_way].valid    = 1'b1;
                    tag_wval[repl_way].asid     = asid;
                    tag_wval[repl_way].vpn_tag  = req_tag;
                    tag_wmask[repl_way]         = '0;
                    pte_wval[repl_way]          = walk_pte;
                    pte_wmask[repl_way]         = '0;
                    next_state                  = ST_HIT;
                end else if (walk_fault) begin
                    next_state = ST_HIT; // no fill
                end
            end
            ST_FENCE: begin
                if (fc_done) begin
                    fence_done = 1'b1;
                    fc_done_n  = 1'b0;
                    next_state = ST_HIT;
                end else begin
                    if (fence_hit) begin
                        sram_wen          = 1'b1;
                        tag_wmask[fc_way] = '0;
                    end
                    if (fc_way == way_idx_t'(TLB_ASSOC - 1)) begin
                        fc_way_n = '0;
                        if (fc_set == set_idx_t'(N_SETS - 1)) begin
                            fc_set_n  = '0;
                            fc_done_n = 1'b1;
                        end else begin
                            fc_set_n = fc_set + 1'b1;
                        end
                    end else begin
                        fc_way_n = fc_way + 1'b1;
                    end
                end
            end
            default: next_state = ST_SWEEP;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= ST_SWEEP;
            fc_set    <= '0;
            fc_way    <= '0;
            fc_done   <= 1'b0;
            last_used <= '0;
        end else begin
            state     <= next_state;
            fc_set    <= fc_set_n;
            fc_way    <= fc_way_n;
            fc_done   <= fc_done_n;
            last_used <= last_used_n;
        end
    end

    // fence operands held for the sweep
    always_ff @(posedge CLK) begin
        if (fence) begin
            fence_va_q   <= fence_va;
            fence_asid_q <= fence_asid;
        end
    end

endmodule

// ==== page_perm_check.sv ====
/*
 * Permission and privilege checks on a TLB hit,
 * one fault per access kind
 */

`timescale 1ns/1ns

module page_perm_check import sv32_pkg::*; (
    input  logic       check,
    input  access_t    access,
    input  logic [1:0] priv,
    input  pte_t       pte,
    output logic       fault_load,
    output logic       fault_store,
    output logic       fault_insn
);

    logic prv_fault;
    logic common_fault;

    // user must hit user pages, supervisor must not
    always_comb begin
        prv_fault = 1'b0;
        if (priv == PRV_U && !pte.perms.user) begin
            prv_fault = 1'b1;
        end else if (priv == PRV_S && pte.perms.user) begin
            prv_fault = 1'b1;
        end
    end

    assign common_fault = !pte.perms.accessed || prv_fault; // no hw A/D update

    assign fault_load  = check && (access == ACCESS_LOAD) &&
                         (!pte.perms.readable || common_fault);

    // store also needs dirty already set
    assign fault_store = check && (access == ACCESS_STORE) &&
                         (!pte.perms.writable || !pte.perms.dirty || common_fault);

    assign fault_insn  = check && (access == ACCESS_INSN) &&
                         (!pte.perms.executable || common_fault);

endmodule

// ==== tlb_sram.sv ====
/*
 * Set-indexed row storage for the TLB,
 * combinational read, registered write under a bit mask
 */

`timescale 1ns/1ns

module tlb_sram import tlb_pkg::*; #(
    parameter type ROW_T = logic
) (
    input  logic     CLK,
    input  logic     nRST,
    input  set_idx_t sel,
    input  logic     wen,
    input  ROW_T     wval,
    input  ROW_T     wmask, // 0 marks bits to write
    output ROW_T     rval
);

    ROW_T mem [N_SETS];

    assign rval = mem[sel];

    always_ff @(posedge CLK) begin
        // writes held off while in reset
        if (nRST && wen) begin
            mem[sel] <= ROW_T'((mem[sel] & wmask) | (wval & ~wmask));
        end
    end

endmodule

// ==== tlb_pkg.sv ====
/*
 * TLB geometry, set and way index types,
 * tag and PTE row types, page table size and walk latency
 */

package tlb_pkg;

    import sv32_pkg::*;

    localparam int TLB_ENTRIES = 16;
    localparam int TLB_ASSOC   = 2;    // ways per set

    localparam int N_SETS      = TLB_ENTRIES / TLB_ASSOC;
    localparam int N_SET_BITS  = (N_SETS > 1) ? $clog2(N_SETS) : 1;
    localparam int N_WAY_BITS  = (TLB_ASSOC > 1) ? $clog2(TLB_ASSOC) : 1;
    localparam int N_TAG_BITS  = VPN_BITS - N_SET_BITS; // vpn bits above the set index

    localparam int PT_ENTRIES   = 64;
    localparam int PT_IDX_BITS  = 6;
    localparam int WALK_LATENCY = 2; // walk_req to answer

    typedef logic [N_SET_BITS-1:0] set_idx_t;
    typedef logic [N_WAY_BITS-1:0] way_idx_t;

    typedef struct packed {
        logic                  valid;
        logic [ASID_BITS-1:0]  asid;
        logic [N_TAG_BITS-1:0] vpn_tag;
    } tlb_tag_t;

    // one row holds every way of a set
    typedef tlb_tag_t [TLB_ASSOC-1:0] tlb_tag_row_t;
    typedef pte_t     [TLB_ASSOC-1:0] tlb_pte_row_t;

endpackage

// ==== sv32_pkg.sv ====
/*
 * Sv32 definitions: data word, page table entry layout,
 * access kinds and privilege encodings
 */

package sv32_pkg;

    localparam int PAGE_OFFSET_BITS = 12;
    localparam int VPN_BITS         = 20;
    localparam int PPN_BITS         = 22;
    localparam int ASID_BITS        = 9;

    localparam logic [1:0] PRV_U = 2'b00; // user mode
    localparam logic [1:0] PRV_S = 2'b01; // supervisor mode

    typedef logic [31:0] word_t;

    // flag bits in Sv32 order, valid at bit 0
    typedef struct packed {
        logic [1:0] reserved; // rsw, free for software
        logic       dirty;
        logic       accessed;
        logic       global_page;
        logic       user;
        logic       executable;
        logic       writable;
        logic       readable;
        logic       valid;
    } pte_perms_t;

    typedef struct packed {
        logic [PPN_BITS-1:0] ppn;
        pte_perms_t          perms;
    } pte_t;

    // kind of access being translated
    typedef enum logic [1:0] {
        ACCESS_NONE,
        ACCESS_LOAD,
        ACCESS_STORE,
        ACCESS_INSN
    } access_t;

endpackage
